//--- build.f
hdl/keypad_pkg.sv
hdl/keypad_scanner.sv
hdl/key_debouncer.sv
hdl/key_decoder.sv
hdl/key_event_fifo.sv
hdl/keypad_wb_slave.sv
hdl/keypad_top.sv
verification/keypad_matrix_model.sv
verification/keypad_tb.sv

//--- Bender.yml
package:
  name: keypad_ctrl

sources:
  # package first, then the pipeline stages and the top level
  - hdl/keypad_pkg.sv
  - hdl/keypad_scanner.sv
  - hdl/key_debouncer.sv
  - hdl/key_decoder.sv
  - hdl/key_event_fifo.sv
  - hdl/keypad_wb_slave.sv
  - hdl/keypad_top.sv
  - target: test
    files:
      - verification/keypad_matrix_model.sv
      - verification/keypad_tb.sv

//--- verification/keypad_tb.sv
`default_nettype none

module keypad_tb
  import keypad_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SCAN_DIV        = 4;
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int FIFO_DEPTH      = 8;
  // press time, debounce margin plus one full scan
  localparam int HOLD_CYCLES     = 4 * DEBOUNCE_CYCLES + 4 * SCAN_DIV;
  localparam int ACK_TIMEOUT     = 10;
  localparam int POLL_TIMEOUT    = 100;

  // legend of the keypad, row by row
  localparam logic [7:0] legend [16] = '{
    "1", "2", "3", "A", "4", "5", "6", "B",
    "7", "8", "9", "C", "*", "0", "#", "D"
  };

  logic        clk;
  logic        nrst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  logic        irq;
  logic [3:0]  scancol;
  logic [3:0]  readrow;
  logic [15:0] key_mask;

  keypad_top #(
    .SCAN_DIV(SCAN_DIV), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)
  ) UUT (
    .clk(clk), .nrst(nrst), .readrow(readrow), .scancol(scancol),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
    .dat_r(dat_r), .ack(ack), .irq(irq)
  );

  keypad_matrix_model matrix (.scancol(scancol), .pressed(key_mask), .readrow(readrow));

  always #10 clk = ~clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else fail_run($sformatf("error at %0t ns: %s expected %h actual %h",
                              $time, name, expected, actual));
  endtask

  // one classic cycle, held until ack, sampled mid-cycle
  task automatic bus_cycle(input logic write, input logic [1:0] word,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = {word, 2'b00};
    dat_w = wdata;
    waited = 0;
    @(negedge clk);
    while (!ack) begin
      if (waited == ACK_TIMEOUT) begin
        fail_run("wishbone slave never raised ack");
      end
      waited++;
      @(negedge clk);
    end
    rdata = dat_r;
    @(posedge clk);
    #1;
    // ack lasts a single cycle
    check_value("ack", 32'd0, 32'(ack));
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic write_reg(input logic [1:0] word, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_cycle(1'b1, word, wdata, unused);
  endtask

  task automatic read_reg(input logic [1:0] word, output logic [31:0] rdata);
    bus_cycle(1'b0, word, 32'd0, rdata);
  endtask

  // poll status until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] want);
    logic [31:0] status;
    int polls;
    polls = 0;
    read_reg(reg_status_addr, status);
    while ((status & mask) != want) begin
      if (polls == POLL_TIMEOUT) begin
        fail_run("status never reached the awaited state");
      end
      polls++;
      read_reg(reg_status_addr, status);
    end
  endtask

  function automatic logic [31:0] status_word(input int cnt, input bit fl, input bit ovf,
                                              input bit gh);
    logic [31:0] w;
    w = 32'd0;
    w[status_nonempty_bit]   = (cnt != 0);
    w[status_full_bit]       = fl;
    w[status_overflow_bit]   = ovf;
    w[status_ghost_bit]      = gh;
    w[status_count_lsb +: 4] = 4'(cnt);
    return w;
  endfunction

  function automatic logic [31:0] data_word(input int k);
    return {1'b1, 15'd0, legend[k], 4'd0, 4'(k)};
  endfunction

  task automatic press_keys(input logic [15:0] keys);
    @(posedge clk);
    #1;
    key_mask = keys;
  endtask

  // open all keys, then give the debouncer its release window
  task automatic release_keys();
    press_keys(16'd0);
    repeat (DEBOUNCE_CYCLES + 8) @(posedge clk);
  endtask

  // scan column sanity, checked all run long
  always @(negedge clk) begin
    if (nrst) begin
      assert (scancol == 4'b1111 || $onehot(~scancol))
        else fail_run($sformatf("error at %0t ns: scancol expected one low bit actual %b",
                                $time, scancol));
    end
  end

  task automatic test_reset();
    logic [31:0] rd;
    check_value("scancol", 32'hf, 32'(scancol));
    check_value("irq", 32'd0, 32'(irq));
    read_reg(reg_ctrl_addr, rd);
    check_value("ctrl", 32'd0, rd);
    read_reg(reg_status_addr, rd);
    check_value("status", 32'd0, rd);
    write_reg(reg_ctrl_addr, 32'd1 << ctrl_enable_bit);
    read_reg(reg_ctrl_addr, rd);
    check_value("ctrl", 32'd1, rd);
  endtask

  task automatic test_each_key();
    logic [31:0] rd;
    for (int k = 0; k < 16; k++) begin
      press_keys(16'd1 << k);
      wait_status(32'd1 << status_nonempty_bit, 32'd1 << status_nonempty_bit);
      repeat (HOLD_CYCLES) @(posedge clk);
      release_keys();
      read_reg(reg_status_addr, rd);
      check_value("status", status_word(1, 0, 0, 0), rd);
      read_reg(reg_data_addr, rd);
      check_value("data", data_word(k), rd);
      read_reg(reg_data_addr, rd);
      check_value("data", 32'd0, rd);
    end
  endtask

  task automatic test_hold_bounce();
    logic [31:0] rd;
    // long hold on key 5
    press_keys(16'd1 << 5);
    wait_status(32'd1 << status_nonempty_bit, 32'd1 << status_nonempty_bit);
    repeat (10 * HOLD_CYCLES) @(posedge clk);
    release_keys();
    read_reg(reg_status_addr, rd);
    check_value("status", status_word(1, 0, 0, 0), rd);
    read_reg(reg_data_addr, rd);
    check_value("data", data_word(5), rd);
    read_reg(reg_data_addr, rd);
    check_value("data", 32'd0, rd);
    // chatter on key 10, each phase shorter than the window
    for (int i = 0; i < 8; i++) begin
      press_keys(16'd1 << 10);
      repeat (6) @(posedge clk);
      press_keys(16'd0);
      repeat (5) @(posedge clk);
    end
    release_keys();
    read_reg(reg_status_addr, rd);
    check_value("status", 32'd0, rd);
  endtask

  task automatic test_ghost();
    logic [31:0] rd;
    // keys 1 and 5 share column 1
    press_keys((16'd1 << 1) | (16'd1 << 5));
    wait_status(32'd1 << status_ghost_bit, 32'd1 << status_ghost_bit);
    release_keys();
    read_reg(reg_status_addr, rd);
    check_value("status", status_word(0, 0, 0, 1), rd);
    write_reg(reg_ctrl_addr, (32'd1 << ctrl_enable_bit) | (32'd1 << ctrl_clear_bit));
    read_reg(reg_status_addr, rd);
    check_value("status", 32'd0, rd);
  endtask

  task automatic test_overflow();
    logic [31:0] rd;
    for (int k = 0; k < 9; k++) begin
      press_keys(16'd1 << k);
      if (k < FIFO_DEPTH) begin
        wait_status(32'hf << status_count_lsb, 32'(k + 1) << status_count_lsb);
      end else begin
        wait_status(32'd1 << status_overflow_bit, 32'd1 << status_overflow_bit);
      end
      release_keys();
    end
    read_reg(reg_status_addr, rd);
    check_value("status", status_word(FIFO_DEPTH, 1, 1, 0), rd);
    check_value("irq", 32'd1, 32'(irq));
    // oldest first, ninth key was dropped
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      read_reg(reg_data_addr, rd);
      check_value("data", data_word(k), rd);
      check_value("irq", 32'(k != FIFO_DEPTH - 1), 32'(irq));
    end
    write_reg(reg_ctrl_addr, (32'd1 << ctrl_enable_bit) | (32'd1 << ctrl_clear_bit));
    read_reg(reg_status_addr, rd);
    check_value("status", 32'd0, rd);
  endtask

  task automatic test_disabled();
    logic [31:0] rd;
    write_reg(reg_ctrl_addr, 32'd0);
    press_keys(16'd1 << 5);
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value("scancol", 32'hf, 32'(scancol));
      check_value("irq", 32'd0, 32'(irq));
    end
    read_reg(reg_status_addr, rd);
    check_value("status", 32'd0, rd);
    press_keys(16'd0);
  endtask

  initial begin
    clk      = 1'b0;
    nrst     = 1'b0;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = 4'd0;
    dat_w    = 32'd0;
    key_mask = 16'd0;
    repeat (8) @(posedge clk);
    #1;
    nrst = 1'b1;
    test_reset();
    test_each_key();
    test_hold_bounce();
    test_ghost();
    test_overflow();
    test_disabled();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/keypad_matrix_model.sv
`default_nettype none

module keypad_matrix_model (
  input  logic [3:0]  scancol,
  input  logic [15:0] pressed,
  output logic [3:0]  readrow
);

  timeunit 1ns;
  timeprecision 1ps;

  // ideal switches, no contact resistance or bounce
  // key k sits on row k/4 and column k%4
  always_comb begin
    readrow = 4'b0000;
    for (int k = 0; k < 16; k++) begin
      // a closed key shorts its row to a low column
      if (pressed[k] && !scancol[k % 4]) begin
        readrow[k / 4] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/keypad_top.sv
`default_nettype none

module keypad_top
  import keypad_pkg::*;
#(
  parameter int SCAN_DIV        = 4,
  parameter int DEBOUNCE_CYCLES = 16,
  parameter int FIFO_DEPTH      = 8
) (
  input  logic        clk,
  input  logic        nrst,
  input  logic [3:0]  readrow,
  output logic [3:0]  scancol,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [3:0]  adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  output logic        irq
);

  key_scan_t  raw_scan;
  key_scan_t  press_scan;
  key_event_t key_event;
  key_event_t head;
  logic       push;
  logic       ghost;
  logic       pop;
  logic       clear;
  logic       enable;
  logic       full;
  logic       overflow;
  logic [3:0] count;

  // scan, debounce, decode, queue, register port
  keypad_scanner #(.SCAN_DIV(SCAN_DIV)) u_scanner (
    .clk(clk), .nrst(nrst), .enable(enable), .readrow(readrow),
    .scancol(scancol), .raw_scan(raw_scan)
  );

  key_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debouncer (
    .clk(clk), .nrst(nrst), .raw_scan(raw_scan), .press_scan(press_scan)
  );

  key_decoder u_decoder (
    .clk(clk), .nrst(nrst), .press_scan(press_scan),
    .key_event(key_event), .push(push), .ghost(ghost)
  );

  key_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .nrst(nrst), .push(push), .key_event(key_event),
    .pop(pop), .clear(clear), .head(head), .count(count),
    .full(full), .overflow(overflow)
  );

  keypad_wb_slave u_wb (
    .clk(clk), .nrst(nrst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .enable(enable), .irq(irq),
    .pop(pop), .clear(clear), .ghost(ghost), .head(head), .count(count),
    .full(full), .overflow(overflow)
  );

endmodule

`default_nettype wire

//--- hdl/keypad_wb_slave.sv
`default_nettype none

module keypad_wb_slave
  import keypad_pkg::*;
(
  input  logic        clk,
  input  logic        nrst,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [3:0]  adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  output logic        enable,
  output logic        irq,
  output logic        pop,
  output logic        clear,
  input  logic        ghost,
  input  key_event_t  head,
  input  logic [3:0]  count,
  input  logic        full,
  input  logic        overflow
);

  logic [1:0] word_sel;
  logic       nonempty;
  logic       ghost_flag;
  logic       ctrl_wr;
  logic       data_rd;

  assign word_sel = adr[3:2];
  assign nonempty = (count != 4'd0);
  // accesses resolve on the ack cycle
  assign ctrl_wr  = ack && we && (word_sel == reg_ctrl_addr);
  assign data_rd  = ack && !we && (word_sel == reg_data_addr);
  assign pop      = data_rd && nonempty;
  assign clear    = ctrl_wr && dat_w[ctrl_clear_bit];
  assign irq      = enable && nonempty;

  // one-cycle ack, request ignored while acking
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      ack <= 1'b0;
    end else begin
      ack <= cyc && stb && !ack;
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      enable <= 1'b0;
    end else if (ctrl_wr) begin
      enable <= dat_w[ctrl_enable_bit];
    end
  end

  // sticky ghost, set wins over clear
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      ghost_flag <= 1'b0;
    end else if (ghost) begin
      ghost_flag <= 1'b1;
    end else if (clear) begin
      ghost_flag <= 1'b0;
    end
  end

  // read mux, quiet outside a read ack
  always_comb begin
    dat_r = 32'd0;
    if (ack && !we) begin
      case (word_sel)
        reg_ctrl_addr: begin
          dat_r[ctrl_enable_bit] = enable;
        end
        reg_status_addr: begin
          dat_r[status_nonempty_bit]       = nonempty;
          dat_r[status_full_bit]           = full;
          dat_r[status_overflow_bit]       = overflow;
          dat_r[status_ghost_bit]          = ghost_flag;
          dat_r[status_count_lsb +: 4]     = count;
        end
        reg_data_addr: begin
          // head is returned as it pops
          if (nonempty) begin
            dat_r[data_valid_bit] = 1'b1;
            dat_r[3:0]            = head.index;
            dat_r[15:8]           = head.ascii;
          end
        end
        default: dat_r = 32'd0;
      endcase
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!nrst)
    ack |=> !ack);

endmodule

`default_nettype wire

//--- hdl/key_event_fifo.sv
`default_nettype none

module key_event_fifo
  import keypad_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic       clk,
  input  logic       nrst,
  input  logic       push,
  input  key_event_t key_event,
  input  logic       pop,
  input  logic       clear,
  output key_event_t head,
  output logic [3:0] count,
  output logic       full,
  output logic       overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  key_event_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == 4'(FIFO_DEPTH));
  // full push is dropped, empty pop is ignored
  assign do_push = push && !full;
  assign do_pop  = pop && (count != 4'd0);
  assign head    = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= key_event;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 4'd0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 4'd1;
      end else if (do_pop && !do_push) begin
        count <= count - 4'd1;
      end
    end
  end

  // sticky until clear, a new drop wins over clear
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end else if (clear) begin
      overflow <= 1'b0;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!nrst)
    count <= 4'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- hdl/key_decoder.sv
`default_nettype none

module key_decoder
  import keypad_pkg::*;
(
  input  logic       clk,
  input  logic       nrst,
  input  key_scan_t  press_scan,
  output key_event_t key_event,
  output logic       push,
  output logic       ghost
);

  logic       single_key;
  logic [3:0] key_index;

  // position of the set bit in a one-hot nibble
  function automatic logic [1:0] onehot_pos(input logic [3:0] v);
    logic [1:0] pos;
    pos = 2'd0;
    for (int i = 0; i < 4; i++) begin
      if (v[i]) begin
        pos = 2'(i);
      end
    end
    return pos;
  endfunction

  // exactly one row and one column, else a ghost or chord
  assign single_key = $onehot(press_scan.row) && $onehot(press_scan.col);
  assign key_index  = {onehot_pos(press_scan.row), onehot_pos(press_scan.col)};

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      push  <= 1'b0;
      ghost <= 1'b0;
    end else begin
      push  <= press_scan.valid && single_key;
      ghost <= press_scan.valid && !single_key;
    end
  end

  // payload only, qualified by push
  always_ff @(posedge clk) begin
    key_event.index <= key_index;
    key_event.ascii <= key_ascii_table[key_index];
  end

  a_push_ghost_excl: assert property (@(posedge clk) disable iff (!nrst)
    !(push && ghost));

endmodule

`default_nettype wire

//--- hdl/key_debouncer.sv
`default_nettype none

module key_debouncer
  import keypad_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic      clk,
  input  logic      nrst,
  input  key_scan_t raw_scan,
  output key_scan_t press_scan
);

  localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES - 1);

  key_scan_t        scan_in;
  key_scan_t        last_scan;
  logic [CNT_W-1:0] stable_cnt;
  logic             pressed;
  logic             settled;

  // idle samples differ only in the rotating column, treat them as one pattern
  assign scan_in = raw_scan.valid ? raw_scan : key_scan_t'(0);

  // pattern unchanged for the full window
  assign settled = (scan_in == last_scan) && (stable_cnt == CNT_MAX);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      last_scan  <= '0;
      stable_cnt <= '0;
    end else if (scan_in != last_scan) begin
      // any change restarts the window
      last_scan  <= scan_in;
      stable_cnt <= '0;
    end else if (stable_cnt != CNT_MAX) begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

  // pressed is set on the event and cleared after a stable release
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      pressed    <= 1'b0;
      press_scan <= '0;
    end else begin
      press_scan.valid <= 1'b0;
      if (settled && !pressed && last_scan.valid) begin
        // single event per press
        pressed          <= 1'b1;
        press_scan.valid <= 1'b1;
        press_scan.row   <= last_scan.row;
        press_scan.col   <= last_scan.col;
      end else if (settled && pressed && !last_scan.valid) begin
        // released long enough, re-arm
        pressed <= 1'b0;
      end
    end
  end

  // event is a single-cycle strobe
  a_press_pulse: assert property (@(posedge clk) disable iff (!nrst)
    press_scan.valid |=> !press_scan.valid);

endmodule

`default_nettype wire

//--- hdl/keypad_scanner.sv
`default_nettype none

module keypad_scanner
  import keypad_pkg::*;
#(
  parameter int SCAN_DIV = 4
) (
  input  logic       clk,
  input  logic       nrst,
  input  logic       enable,
  input  logic [3:0] readrow,
  output logic [3:0] scancol,
  output key_scan_t  raw_scan
);

  localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

  logic [3:0]       row_meta;
  logic [3:0]       row_sync;
  logic [3:0]       col_d1;
  logic [3:0]       col_d2;
  logic [DIV_W-1:0] div_cnt;
  logic             row_hit;

  // two-flop sync, rows are async to clk
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      row_meta <= 4'b0000;
      row_sync <= 4'b0000;
    end else begin
      row_meta <= readrow;
      row_sync <= row_meta;
    end
  end

  // column delayed by the same two stages
  // so the reported column matches the synced rows
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      col_d1 <= 4'b1111;
      col_d2 <= 4'b1111;
    end else begin
      col_d1 <= scancol;
      col_d2 <= col_d1;
    end
  end

  assign row_hit = |row_sync;

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      scancol <= 4'b1111;
      div_cnt <= '0;
    end else if (!enable) begin
      // idle, no column driven
      scancol <= 4'b1111;
      div_cnt <= '0;
    end else if (scancol == 4'b1111) begin
      // first column after enable
      scancol <= 4'b1110;
      div_cnt <= '0;
    end else if (row_hit) begin
      // key seen, park on this column
      div_cnt <= '0;
    end else if (div_cnt == DIV_LAST) begin
      scancol <= {scancol[2:0], scancol[3]};
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // raw pattern, valid while any row is high
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      raw_scan <= '0;
    end else begin
      raw_scan.valid <= row_hit;
      raw_scan.row   <= row_sync;
      raw_scan.col   <= ~col_d2;
    end
  end

  // never more than one column low
  a_scancol_onehot: assert property (@(posedge clk) disable iff (!nrst)
    (scancol == 4'b1111) || $onehot(~scancol));

endmodule

`default_nettype wire

//--- hdl/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

  // raw sample from the scanner
  // col is the inverse of the driven scan column, so one-hot high
  typedef struct packed {
    logic       valid;
    logic [3:0] row;
    logic [3:0] col;
  } key_scan_t;

  // decoded press, index is row*4 + col
  typedef struct packed {
    logic [3:0] index;
    logic [7:0] ascii;
  } key_event_t;

  // keypad legend, indexed by key index
  localparam logic [7:0] key_ascii_table [16] = '{
    "1", "2", "3", "A",
    "4", "5", "6", "B",
    "7", "8", "9", "C",
    "*", "0", "#", "D"
  };

  // word offsets, taken from adr[3:2]
  localparam logic [1:0] reg_ctrl_addr   = 2'd0;
  localparam logic [1:0] reg_status_addr = 2'd1;
  localparam logic [1:0] reg_data_addr   = 2'd2;

  // ctrl fields
  localparam int unsigned ctrl_enable_bit = 0;
  localparam int unsigned ctrl_clear_bit  = 1;

  // status fields, count sits in 7:4
  localparam int unsigned status_nonempty_bit = 0;
  localparam int unsigned status_full_bit     = 1;
  localparam int unsigned status_overflow_bit = 2;
  localparam int unsigned status_ghost_bit    = 3;
  localparam int unsigned status_count_lsb    = 4;

  // data fields, index in 3:0, ascii in 15:8
  localparam int unsigned data_valid_bit = 31;

endpackage

`default_nettype wire
